// File: mipsControl_defines.svh
`ifndef MIPS_CONTROL_DEFINES_SVH
`define MIPS_CONTROL_DEFINES_SVH

// Field and code widths
`define OPCODE_W 6
`define FUNCT_W  6
`define ALUOP_W  4
`define SEL_W    2
`define SIZE_W   2

// Opcodes
`define OP_RTYPE 6'h00
`define OP_J     6'h02
`define OP_JAL   6'h03
`define OP_BEQ   6'h04
`define OP_BNE   6'h05
`define OP_BLE   6'h06
`define OP_BGT   6'h07
`define OP_ADDI  6'h08
`define OP_ADDIU 6'h09
`define OP_LB    6'h20
`define OP_LH    6'h21
`define OP_LW    6'h23
`define OP_SB    6'h28
`define OP_SH    6'h29
`define OP_SW    6'h2B

// R-type functs
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2A

// ALU operation codes
`define ALU_PASS_A 4'd0
`define ALU_ADD    4'd1
`define ALU_SUB    4'd2
`define ALU_AND    4'd3
`define ALU_SLT    4'd10
`define ALU_BEQ    4'd11
`define ALU_BNE    4'd12
`define ALU_BLE    4'd13
`define ALU_BGT    4'd14

// Load/store access sizes
`define SIZE_NONE 2'd0
`define SIZE_BYTE 2'd1
`define SIZE_HALF 2'd2
`define SIZE_WORD 2'd3

// Datapath mux selects
`define PCSRC_ALUOUT 2'd0  // Branch target
`define PCSRC_ALU    2'd1  // PC + 4
`define PCSRC_JUMP   2'd2
`define SRCA_PC      2'd0
`define SRCA_REGA    2'd1
`define SRCB_REGB    2'd0
`define SRCB_FOUR    2'd1
`define SRCB_IMM     2'd2
`define SRCB_BROFF   2'd3
`define DST_RT       2'd0
`define DST_RD       2'd1
`define DST_RA       2'd3
`define WDATA_ALUOUT 2'd0
`define WDATA_MDR    2'd1
`define WDATA_PC     2'd2

`endif

// File: mipsCtrlPkg.sv
`default_nettype none

`include "mipsControl_defines.svh"

package mipsCtrlPkg;

  typedef logic [`OPCODE_W-1:0] opcode_t;
  typedef logic [`FUNCT_W-1:0] funct_t;
  typedef logic [`ALUOP_W-1:0] aluOp_t;
  typedef logic [`SEL_W-1:0] sel_t;
  typedef logic [`SIZE_W-1:0] accessSize_t;

  typedef enum logic [2:0] {
    RESET,
    FETCH,
    DECODE,
    EXECUTE,
    MEMORY,
    WRITEBACK,
    JUMP
  } phase_t;

  typedef enum logic [2:0] {
    ALU_REG,
    ALU_IMM,
    BRANCH,
    JUMP_PLAIN,
    JUMP_LINK,
    LOAD,
    STORE,
    NONE
  } instrClass_t;

  // Wishbone classic master request
  typedef struct packed {
    logic cyc;
    logic stb;
    logic we;
    logic adrFromAluOut;  // Address from ALUOut, else PC
  } memReq_t;

  typedef struct packed {
    logic pcWrite;
    logic irWrite;
    logic regAWrite;
    logic regBWrite;
    logic aluOutWrite;
    logic mdrWrite;
    logic regWrite;
    sel_t pcSrc;
    sel_t aluSrcA;
    sel_t aluSrcB;
    sel_t regDst;
    sel_t regData;
    aluOp_t aluOp;
    accessSize_t loadSize;
    accessSize_t storeSize;
  } ctrlWord_t;

endpackage

`default_nettype wire

// File: instrDecoder.sv
`default_nettype none
`timescale 1ns/1ns

`include "mipsControl_defines.svh"

module instrDecoder (
  input wire mipsCtrlPkg::opcode_t opcode,
  input wire mipsCtrlPkg::funct_t funct,
  output mipsCtrlPkg::instrClass_t cls,
  output mipsCtrlPkg::aluOp_t op,
  output mipsCtrlPkg::accessSize_t size,
  output mipsCtrlPkg::sel_t dst
);

  always_comb begin
    cls = mipsCtrlPkg::NONE;
    op = `ALU_PASS_A;
    size = `SIZE_NONE;
    dst = `DST_RT;
    case (opcode)
      `OP_RTYPE: begin
        cls = mipsCtrlPkg::ALU_REG;
        dst = `DST_RD;
        case (funct)
          `FN_ADD: op = `ALU_ADD;
          `FN_SUB: op = `ALU_SUB;
          `FN_AND: op = `ALU_AND;
          `FN_SLT: op = `ALU_SLT;
          default: cls = mipsCtrlPkg::NONE;  // Unsupported funct
        endcase
      end
      `OP_ADDI, `OP_ADDIU: begin
        cls = mipsCtrlPkg::ALU_IMM;
        op = `ALU_ADD;
      end
      `OP_BEQ: begin
        cls = mipsCtrlPkg::BRANCH;
        op = `ALU_BEQ;
      end
      `OP_BNE: begin
        cls = mipsCtrlPkg::BRANCH;
        op = `ALU_BNE;
      end
      `OP_BLE: begin
        cls = mipsCtrlPkg::BRANCH;
        op = `ALU_BLE;
      end
      `OP_BGT: begin
        cls = mipsCtrlPkg::BRANCH;
        op = `ALU_BGT;
      end
      `OP_J: cls = mipsCtrlPkg::JUMP_PLAIN;
      `OP_JAL: begin
        cls = mipsCtrlPkg::JUMP_LINK;
        dst = `DST_RA;
      end
      `OP_LW, `OP_LH, `OP_LB: begin
        cls = mipsCtrlPkg::LOAD;
        op = `ALU_ADD;  // Base plus offset
        size = (opcode == `OP_LW) ? `SIZE_WORD :
               (opcode == `OP_LH) ? `SIZE_HALF : `SIZE_BYTE;
      end
      `OP_SW, `OP_SH, `OP_SB: begin
        cls = mipsCtrlPkg::STORE;
        op = `ALU_ADD;
        size = (opcode == `OP_SW) ? `SIZE_WORD :
               (opcode == `OP_SH) ? `SIZE_HALF : `SIZE_BYTE;
      end
      default: cls = mipsCtrlPkg::NONE;
    endcase
  end

endmodule

`default_nettype wire

// File: phaseSequencer.sv
`default_nettype none
`timescale 1ns/1ns

module phaseSequencer (
  input wire clk,
  input wire reset_in,
  input wire mipsCtrlPkg::instrClass_t cls,
  input wire memAck,
  output mipsCtrlPkg::phase_t phase
);

  mipsCtrlPkg::phase_t nextPhase;

  always_ff @(posedge clk) begin
    if (reset_in) begin
      phase <= mipsCtrlPkg::RESET;
    end else begin
      phase <= nextPhase;
    end
  end

  always_comb begin
    nextPhase = phase;
    case (phase)
      mipsCtrlPkg::RESET: nextPhase = mipsCtrlPkg::FETCH;  // One cycle after reset drops
      mipsCtrlPkg::FETCH: begin
        if (memAck) begin
          nextPhase = mipsCtrlPkg::DECODE;
        end
      end
      mipsCtrlPkg::DECODE: begin
        case (cls)
          mipsCtrlPkg::NONE: nextPhase = mipsCtrlPkg::FETCH;
          mipsCtrlPkg::JUMP_PLAIN,
          mipsCtrlPkg::JUMP_LINK: nextPhase = mipsCtrlPkg::JUMP;
          default: nextPhase = mipsCtrlPkg::EXECUTE;
        endcase
      end
      mipsCtrlPkg::EXECUTE: begin
        case (cls)
          mipsCtrlPkg::ALU_REG,
          mipsCtrlPkg::ALU_IMM: nextPhase = mipsCtrlPkg::WRITEBACK;
          mipsCtrlPkg::LOAD,
          mipsCtrlPkg::STORE: nextPhase = mipsCtrlPkg::MEMORY;
          default: nextPhase = mipsCtrlPkg::FETCH;  // Branch done
        endcase
      end
      mipsCtrlPkg::MEMORY: begin
        // Held until the slave acks
        if (memAck) begin
          if (cls == mipsCtrlPkg::LOAD) begin
            nextPhase = mipsCtrlPkg::WRITEBACK;
          end else begin
            nextPhase = mipsCtrlPkg::FETCH;
          end
        end
      end
      mipsCtrlPkg::WRITEBACK: nextPhase = mipsCtrlPkg::FETCH;
      mipsCtrlPkg::JUMP: nextPhase = mipsCtrlPkg::FETCH;
      default: nextPhase = mipsCtrlPkg::RESET;
    endcase
  end

endmodule

`default_nettype wire

// File: controlWordGen.sv
`default_nettype none
`timescale 1ns/1ns

`include "mipsControl_defines.svh"

module controlWordGen (
  input wire mipsCtrlPkg::phase_t phase,
  input wire mipsCtrlPkg::instrClass_t cls,
  input wire mipsCtrlPkg::aluOp_t op,
  input wire mipsCtrlPkg::accessSize_t size,
  input wire mipsCtrlPkg::sel_t dst,
  input wire memAck,
  input wire branchCond,
  output mipsCtrlPkg::ctrlWord_t ctrl,
  output mipsCtrlPkg::memReq_t mem,
  output logic resetOut
);

  always_comb begin
    ctrl = '0;
    mem = '0;
    resetOut = 1'b0;
    case (phase)
      mipsCtrlPkg::RESET: resetOut = 1'b1;
      mipsCtrlPkg::FETCH: begin
        mem.cyc = 1'b1;
        mem.stb = 1'b1;
        mem.we = 1'b0;
        mem.adrFromAluOut = 1'b0;  // Address from PC
        ctrl.aluSrcA = `SRCA_PC;
        ctrl.aluSrcB = `SRCB_FOUR;
        ctrl.aluOp = `ALU_ADD;
        ctrl.pcSrc = `PCSRC_ALU;
        ctrl.irWrite = memAck;  // Capture only on ack
        ctrl.pcWrite = memAck;
      end
      mipsCtrlPkg::DECODE: begin
        ctrl.regAWrite = 1'b1;
        ctrl.regBWrite = 1'b1;
        ctrl.aluSrcA = `SRCA_PC;
        ctrl.aluSrcB = `SRCB_BROFF;  // Branch target into ALUOut
        ctrl.aluOp = `ALU_ADD;
        ctrl.aluOutWrite = 1'b1;
      end
      mipsCtrlPkg::EXECUTE: begin
        ctrl.aluSrcA = `SRCA_REGA;
        ctrl.aluOp = op;
        case (cls)
          mipsCtrlPkg::ALU_REG: begin
            ctrl.aluSrcB = `SRCB_REGB;
            ctrl.aluOutWrite = 1'b1;
          end
          mipsCtrlPkg::ALU_IMM,
          mipsCtrlPkg::LOAD,
          mipsCtrlPkg::STORE: begin
            ctrl.aluSrcB = `SRCB_IMM;
            ctrl.aluOutWrite = 1'b1;
          end
          mipsCtrlPkg::BRANCH: begin
            ctrl.aluSrcB = `SRCB_REGB;
            ctrl.pcSrc = `PCSRC_ALUOUT;
            ctrl.pcWrite = branchCond;  // Taken only
          end
          default: ctrl.aluOp = `ALU_PASS_A;
        endcase
      end
      mipsCtrlPkg::MEMORY: begin
        mem.cyc = 1'b1;
        mem.stb = 1'b1;
        mem.adrFromAluOut = 1'b1;
        if (cls == mipsCtrlPkg::STORE) begin
          mem.we = 1'b1;
          ctrl.storeSize = size;
        end else begin
          ctrl.loadSize = size;
          ctrl.mdrWrite = memAck;
        end
      end
      mipsCtrlPkg::WRITEBACK: begin
        ctrl.regWrite = 1'b1;
        ctrl.regDst = dst;
        if (cls == mipsCtrlPkg::LOAD) begin
          ctrl.regData = `WDATA_MDR;
        end else begin
          ctrl.regData = `WDATA_ALUOUT;
        end
      end
      mipsCtrlPkg::JUMP: begin
        ctrl.pcWrite = 1'b1;
        ctrl.pcSrc = `PCSRC_JUMP;
        if (cls == mipsCtrlPkg::JUMP_LINK) begin
          ctrl.regWrite = 1'b1;
          ctrl.regDst = dst;
          ctrl.regData = `WDATA_PC;  // Return address is PC + 4
        end
      end
      default: resetOut = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

// File: controlUnit.sv
`default_nettype none
`timescale 1ns/1ns

module controlUnit (
  input wire clk,
  input wire reset_in,
  input wire mipsCtrlPkg::opcode_t opcode,
  input wire mipsCtrlPkg::funct_t funct,
  input wire branchCond,
  input wire memAck,
  output mipsCtrlPkg::ctrlWord_t ctrl,
  output mipsCtrlPkg::memReq_t mem,
  output logic resetOut
);

  mipsCtrlPkg::instrClass_t cls;
  mipsCtrlPkg::aluOp_t op;
  mipsCtrlPkg::accessSize_t size;
  mipsCtrlPkg::sel_t dst;
  mipsCtrlPkg::phase_t phase;

  instrDecoder decoder0 (
    .opcode(opcode),
    .funct(funct),
    .cls(cls),
    .op(op),
    .size(size),
    .dst(dst)
  );

  phaseSequencer sequencer0 (
    .clk(clk),
    .reset_in(reset_in),
    .cls(cls),
    .memAck(memAck),
    .phase(phase)
  );

  controlWordGen wordGen0 (
    .phase(phase),
    .cls(cls),
    .op(op),
    .size(size),
    .dst(dst),
    .memAck(memAck),
    .branchCond(branchCond),
    .ctrl(ctrl),
    .mem(mem),
    .resetOut(resetOut)
  );

endmodule

`default_nettype wire

// File: tb_controlUnit.sv
`default_nettype none
`timescale 1ns/1ns

`include "mipsControl_defines.svh"

module tb_controlUnit;

  typedef struct packed {
    mipsCtrlPkg::opcode_t opc;
    mipsCtrlPkg::funct_t fn;
    mipsCtrlPkg::instrClass_t cls;
    mipsCtrlPkg::aluOp_t aluOp;
    mipsCtrlPkg::accessSize_t size;
    mipsCtrlPkg::sel_t dst;
  } instr_t;

  logic clk;
  logic reset_in;
  mipsCtrlPkg::opcode_t opcode;
  mipsCtrlPkg::funct_t funct;
  logic branchCond;
  logic memAck;
  mipsCtrlPkg::ctrlWord_t ctrl;
  mipsCtrlPkg::memReq_t mem;
  logic resetOut;

  instr_t prog[$];
  instr_t curInstr;
  mipsCtrlPkg::phase_t curPh;  // Model of the DUT phase
  mipsCtrlPkg::phase_t nextPh;
  logic [31:0] lfsr;
  int waitLeft;
  int idx;
  int cycles;
  int limit;
  int errors;
  int testErr;
  int testNum;
  int checks;
  logic done;

  controlUnit dut0 (
    .clk(clk),
    .reset_in(reset_in),
    .opcode(opcode),
    .funct(funct),
    .branchCond(branchCond),
    .memAck(memAck),
    .ctrl(ctrl),
    .mem(mem),
    .resetOut(resetOut)
  );

  always #4 clk = ~clk;

  function automatic logic lfsrBit();
    logic outBit;
    outBit = lfsr[0];
    lfsr = lfsr >> 1;
    if (outBit) begin
      lfsr = lfsr ^ 32'h80200003;
    end
    return outBit;
  endfunction

  function automatic logic isBus(input mipsCtrlPkg::phase_t p);
    return p == mipsCtrlPkg::FETCH || p == mipsCtrlPkg::MEMORY;
  endfunction

  function automatic void addInstr(input mipsCtrlPkg::opcode_t o, input mipsCtrlPkg::funct_t f,
                                   input mipsCtrlPkg::instrClass_t c, input mipsCtrlPkg::aluOp_t a,
                                   input mipsCtrlPkg::accessSize_t s, input mipsCtrlPkg::sel_t d);
    instr_t e;
    e = '{o, f, c, a, s, d};
    prog.push_back(e);
  endfunction

  task automatic buildProgram();
    repeat (3) begin
      addInstr(`OP_RTYPE, `FN_ADD, mipsCtrlPkg::ALU_REG, `ALU_ADD, `SIZE_NONE, `DST_RD);
      addInstr(`OP_RTYPE, `FN_SUB, mipsCtrlPkg::ALU_REG, `ALU_SUB, `SIZE_NONE, `DST_RD);
      addInstr(`OP_RTYPE, `FN_AND, mipsCtrlPkg::ALU_REG, `ALU_AND, `SIZE_NONE, `DST_RD);
      addInstr(`OP_RTYPE, `FN_SLT, mipsCtrlPkg::ALU_REG, `ALU_SLT, `SIZE_NONE, `DST_RD);
      addInstr(`OP_ADDI, 6'h15, mipsCtrlPkg::ALU_IMM, `ALU_ADD, `SIZE_NONE, `DST_RT);
      addInstr(`OP_ADDIU, 6'h2A, mipsCtrlPkg::ALU_IMM, `ALU_ADD, `SIZE_NONE, `DST_RT);
      addInstr(`OP_BEQ, 6'h00, mipsCtrlPkg::BRANCH, `ALU_BEQ, `SIZE_NONE, `DST_RT);
      addInstr(`OP_BNE, 6'h01, mipsCtrlPkg::BRANCH, `ALU_BNE, `SIZE_NONE, `DST_RT);
      addInstr(`OP_BLE, 6'h02, mipsCtrlPkg::BRANCH, `ALU_BLE, `SIZE_NONE, `DST_RT);
      addInstr(`OP_BGT, 6'h03, mipsCtrlPkg::BRANCH, `ALU_BGT, `SIZE_NONE, `DST_RT);
      addInstr(`OP_LW, 6'h04, mipsCtrlPkg::LOAD, `ALU_ADD, `SIZE_WORD, `DST_RT);
      addInstr(`OP_LH, 6'h05, mipsCtrlPkg::LOAD, `ALU_ADD, `SIZE_HALF, `DST_RT);
      addInstr(`OP_LB, 6'h06, mipsCtrlPkg::LOAD, `ALU_ADD, `SIZE_BYTE, `DST_RT);
      addInstr(`OP_SW, 6'h07, mipsCtrlPkg::STORE, `ALU_ADD, `SIZE_WORD, `DST_RT);
      addInstr(`OP_SH, 6'h08, mipsCtrlPkg::STORE, `ALU_ADD, `SIZE_HALF, `DST_RT);
      addInstr(`OP_SB, 6'h09, mipsCtrlPkg::STORE, `ALU_ADD, `SIZE_BYTE, `DST_RT);
      addInstr(`OP_J, 6'h0A, mipsCtrlPkg::JUMP_PLAIN, `ALU_PASS_A, `SIZE_NONE, `DST_RT);
      addInstr(`OP_JAL, 6'h0B, mipsCtrlPkg::JUMP_LINK, `ALU_PASS_A, `SIZE_NONE, `DST_RA);
      addInstr(`OP_RTYPE, 6'h00, mipsCtrlPkg::NONE, `ALU_PASS_A, `SIZE_NONE, `DST_RT);  // sll
      addInstr(6'h0F, 6'h00, mipsCtrlPkg::NONE, `ALU_PASS_A, `SIZE_NONE, `DST_RT);  // lui
    end
  endtask

  task automatic expectOutputs(output mipsCtrlPkg::ctrlWord_t c, output mipsCtrlPkg::memReq_t m,
                               output logic r);
    logic isBr;
    logic isSt;
    logic link;
    isBr = curInstr.cls == mipsCtrlPkg::BRANCH;
    isSt = curInstr.cls == mipsCtrlPkg::STORE;
    link = curInstr.cls == mipsCtrlPkg::JUMP_LINK;
    m = '{cyc: isBus(curPh), stb: isBus(curPh), we: curPh == mipsCtrlPkg::MEMORY && isSt,
          adrFromAluOut: curPh == mipsCtrlPkg::MEMORY};
    r = curPh == mipsCtrlPkg::RESET;
    case (curPh)
      mipsCtrlPkg::FETCH:
        c = '{pcWrite: memAck, irWrite: memAck, pcSrc: `PCSRC_ALU, aluSrcA: `SRCA_PC,
              aluSrcB: `SRCB_FOUR, aluOp: `ALU_ADD, default: '0};
      mipsCtrlPkg::DECODE:
        c = '{regAWrite: 1'b1, regBWrite: 1'b1, aluOutWrite: 1'b1, aluSrcA: `SRCA_PC,
              aluSrcB: `SRCB_BROFF, aluOp: `ALU_ADD, default: '0};
      mipsCtrlPkg::EXECUTE:
        c = '{aluSrcA: `SRCA_REGA, aluOp: curInstr.aluOp, aluOutWrite: !isBr,
              aluSrcB: (isBr || curInstr.cls == mipsCtrlPkg::ALU_REG) ? `SRCB_REGB : `SRCB_IMM,
              pcWrite: isBr && branchCond, pcSrc: `PCSRC_ALUOUT, default: '0};
      mipsCtrlPkg::MEMORY:
        c = '{loadSize: isSt ? `SIZE_NONE : curInstr.size,
              storeSize: isSt ? curInstr.size : `SIZE_NONE,
              mdrWrite: !isSt && memAck, default: '0};
      mipsCtrlPkg::WRITEBACK:
        c = '{regWrite: 1'b1, regDst: curInstr.dst, default: '0,
              regData: (curInstr.cls == mipsCtrlPkg::LOAD) ? `WDATA_MDR : `WDATA_ALUOUT};
      mipsCtrlPkg::JUMP:
        c = '{pcWrite: 1'b1, pcSrc: `PCSRC_JUMP, regWrite: link,
              regDst: link ? `DST_RA : `DST_RT,
              regData: link ? `WDATA_PC : `WDATA_ALUOUT, default: '0};
      default: c = '0;
    endcase
  endtask

  function automatic mipsCtrlPkg::phase_t followingPhase();
    mipsCtrlPkg::phase_t p;
    mipsCtrlPkg::instrClass_t k;
    k = curInstr.cls;
    case (curPh)
      mipsCtrlPkg::RESET: p = mipsCtrlPkg::FETCH;
      mipsCtrlPkg::FETCH: p = memAck ? mipsCtrlPkg::DECODE : mipsCtrlPkg::FETCH;
      mipsCtrlPkg::DECODE: begin
        if (k == mipsCtrlPkg::NONE) begin
          p = mipsCtrlPkg::FETCH;
        end else if (k == mipsCtrlPkg::JUMP_PLAIN || k == mipsCtrlPkg::JUMP_LINK) begin
          p = mipsCtrlPkg::JUMP;
        end else begin
          p = mipsCtrlPkg::EXECUTE;
        end
      end
      mipsCtrlPkg::EXECUTE: begin
        if (k == mipsCtrlPkg::ALU_REG || k == mipsCtrlPkg::ALU_IMM) begin
          p = mipsCtrlPkg::WRITEBACK;
        end else if (k == mipsCtrlPkg::LOAD || k == mipsCtrlPkg::STORE) begin
          p = mipsCtrlPkg::MEMORY;
        end else begin
          p = mipsCtrlPkg::FETCH;
        end
      end
      mipsCtrlPkg::MEMORY: begin
        if (!memAck) begin
          p = mipsCtrlPkg::MEMORY;
        end else begin
          p = (k == mipsCtrlPkg::LOAD) ? mipsCtrlPkg::WRITEBACK : mipsCtrlPkg::FETCH;
        end
      end
      default: p = mipsCtrlPkg::FETCH;  // Writeback and jump
    endcase
    if (reset_in) begin
      p = mipsCtrlPkg::RESET;
    end
    return p;
  endfunction

  task automatic reportValue(input string name, input logic [31:0] expV, input logic [31:0] gotV);
    $display("ERR t=%0t %s expected %h got %h", $time, name, expV, gotV);
    errors++;
    testErr++;
  endtask

  task automatic reportTest();
    if (testNum == 0) begin
      $display("test 0 reset: %s", (testErr == 0) ? "ok" : "failed");
    end else begin
      $display("test %0d opcode %h funct %h: %s", testNum, curInstr.opc, curInstr.fn,
               (testErr == 0) ? "ok" : "failed");
    end
    testNum++;
    testErr = 0;
  endtask

  always @(posedge clk) begin : stimulus
    int w;
    cycles <= cycles + 1;
    if (cycles == 1) begin
      reset_in <= 1'b0;
    end
    branchCond <= lfsrBit();
    curPh <= nextPh;
    if (memAck && curPh == mipsCtrlPkg::FETCH && idx < prog.size()) begin  // IR load
      opcode <= prog[idx].opc;
      funct <= prog[idx].fn;
      curInstr <= prog[idx];
      idx <= idx + 1;
    end
    if (!isBus(nextPh)) begin
      memAck <= 1'b0;
    end else if (memAck || !isBus(curPh)) begin
      w = 0;
      if (lfsrBit()) begin
        w = w + 2;
      end
      if (lfsrBit()) begin
        w = w + 1;
      end
      memAck <= (w == 0);
      waitLeft <= w;
    end else begin
      memAck <= (waitLeft == 1);
      waitLeft <= waitLeft - 1;
    end
  end

  always @(negedge clk) begin : outputCheck
    mipsCtrlPkg::ctrlWord_t expC;
    mipsCtrlPkg::memReq_t expM;
    logic expR;
    if (!done) begin
      expectOutputs(expC, expM, expR);
      checks += 3;
      assert (ctrl === expC) else reportValue("ctrl", 32'(expC), 32'(ctrl));
      assert (mem === expM) else reportValue("mem", 32'(expM), 32'(mem));
      assert (resetOut === expR) else reportValue("resetOut", 32'(expR), 32'(resetOut));
      if (curPh == mipsCtrlPkg::FETCH && memAck) begin
        reportTest();
        if (idx == prog.size()) begin
          done = 1'b1;
        end
      end
      nextPh = followingPhase();
    end
  end

  initial begin
    clk = 1'b0;
    reset_in = 1'b1;
    opcode = '0;
    funct = '0;
    branchCond = 1'b0;
    memAck = 1'b0;
    lfsr = 32'd80675;
    curPh = mipsCtrlPkg::RESET;
    nextPh = mipsCtrlPkg::RESET;
    curInstr = '0;
    waitLeft = 0;
    idx = 0;
    cycles = 0;
    errors = 0;
    testErr = 0;
    testNum = 0;
    checks = 0;
    done = 1'b0;
    buildProgram();
    limit = prog.size() * 11 + 20;  // Load with both waits at 3
    while (!done && cycles < limit) begin
      @(posedge clk);
    end
    if (!done) begin
      $display("Timeout: program did not complete within %0d cycles", limit);
      errors++;
    end
    $display("tests %0d, checks %0d, errors %0d", testNum, checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: mipsControl.f
+incdir+.
mipsCtrlPkg.sv
instrDecoder.sv
phaseSequencer.sv
controlWordGen.sv
controlUnit.sv
tb_controlUnit.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --assert
TOP      = tb_controlUnit
FILELIST = mipsControl.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out=$$(./$(BUILD)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(BUILD)
